// ==== design/wave_pkg.sv ====
package wave_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  nibble_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [10:0] freq_t;
	typedef logic [8:0]  len_t;      // 1..256 remaining ticks
	typedef logic [1:0]  vol_code_t;
	typedef logic [4:0]  wave_pos_t; // nibble index

	localparam reg_addr_t ADDR_NR30 = 5'd0;
	localparam reg_addr_t ADDR_NR31 = 5'd1;
	localparam reg_addr_t ADDR_NR32 = 5'd2;
	localparam reg_addr_t ADDR_NR33 = 5'd3;
	localparam reg_addr_t ADDR_NR34 = 5'd4;

	localparam len_t       LEN_MAX     = 9'd256;
	localparam logic [11:0] PERIOD_BASE = 12'd2048;

	typedef struct packed {
		logic      write;
		reg_addr_t addr;
		byte_t     wdata;
	} cpu_req_t;

	typedef struct packed {
		logic      dac_on;
		vol_code_t vol;
		freq_t     freq;
		logic      length_en;
	} ch3_cfg_t;

	typedef enum logic [1:0] {IDLE, PLAY, HALT} ctrl_state_t;

endpackage

// ==== design/wave_regs.sv ====
`timescale 1ns/100ps

module wave_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               req_valid,
	input  wave_pkg::cpu_req_t req,
	input  wave_pkg::byte_t    ram_rdata,
	output wave_pkg::byte_t    rdata,
	output logic               rsp_valid,
	output wave_pkg::ch3_cfg_t cfg,
	output logic               trigger,
	output logic               len_load,
	output wave_pkg::len_t     len_value,
	output logic               ram_we,
	output logic [3:0]         ram_addr,
	output wave_pkg::byte_t    ram_wdata
);

	logic            wr_en;
	logic            rd_en;
	logic            is_wave;
	wave_pkg::byte_t reg_rdata;

	assign wr_en   = req_valid && req.write;
	assign rd_en   = req_valid && !req.write;
	assign is_wave = req.addr[4]; // 16..31 is wave ram

	assign ram_we    = wr_en && is_wave;
	assign ram_addr  = req.addr[3:0];
	assign ram_wdata = req.wdata;

	// unused bits read back as ones
	always_comb begin
		case (req.addr)
			wave_pkg::ADDR_NR30: reg_rdata = {cfg.dac_on, 7'h7f};
			wave_pkg::ADDR_NR32: reg_rdata = {1'b1, cfg.vol, 5'h1f};
			wave_pkg::ADDR_NR34: reg_rdata = {1'b1, cfg.length_en, 6'h3f};
			default:             reg_rdata = 8'hff; // nr31, nr33, holes
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg       <= '0;
			trigger   <= 1'b0;
			len_load  <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			trigger   <= 1'b0;
			len_load  <= 1'b0;
			rsp_valid <= rd_en;
			if (wr_en) begin
				case (req.addr)
					wave_pkg::ADDR_NR30: cfg.dac_on <= req.wdata[7];
					wave_pkg::ADDR_NR31: len_load <= 1'b1;
					wave_pkg::ADDR_NR32: cfg.vol <= req.wdata[6:5];
					wave_pkg::ADDR_NR33: cfg.freq[7:0] <= req.wdata;
					wave_pkg::ADDR_NR34: begin
						cfg.freq[10:8] <= req.wdata[2:0];
						cfg.length_en  <= req.wdata[6];
						trigger        <= req.wdata[7];
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rdata <= is_wave ? ram_rdata : reg_rdata;
		len_value <= wave_pkg::LEN_MAX - {1'b0, req.wdata}; // only sampled with len_load
	end

endmodule

// ==== design/wave_ctrl.sv ====
`timescale 1ns/100ps

module wave_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  wave_pkg::ch3_cfg_t  cfg,
	input  logic                trigger,
	input  logic                step,
	input  logic                expired,
	output logic                active,
	output logic                restart,
	output wave_pkg::wave_pos_t pos,
	output logic                load_sample
);

	wave_pkg::ctrl_state_t state;
	wave_pkg::ctrl_state_t state_next;

	// trigger only counts with the dac powered
	assign restart = trigger && cfg.dac_on;
	assign active  = (state == wave_pkg::PLAY);

	always_comb begin
		state_next = state;
		case (state)
			wave_pkg::IDLE: begin
				if (restart)
					state_next = wave_pkg::PLAY;
			end
			wave_pkg::PLAY: begin
				if (restart)
					state_next = wave_pkg::PLAY; // retrigger restarts in place
				else if (!cfg.dac_on || expired)
					state_next = wave_pkg::HALT;
			end
			wave_pkg::HALT: begin
				if (restart)
					state_next = wave_pkg::PLAY;
			end
			default: state_next = wave_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= wave_pkg::IDLE;
		else
			state <= state_next;
	end

	// position advances one nibble per step, wraps 31 -> 0
	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
		end else if (restart) begin
			pos <= '0;
		end else if (step && active) begin
			pos <= pos + 5'd1;
		end
	end

	// output stage picks up the nibble once pos has moved
	always_ff @(posedge clk) begin
		if (reset)
			load_sample <= 1'b0;
		else
			load_sample <= step && !restart;
	end

endmodule

// ==== design/wave_freq_timer.sv ====
`timescale 1ns/100ps

module wave_freq_timer (
	input  logic            clk,
	input  logic            reset,
	input  logic            restart,
	input  logic            run,
	input  wave_pkg::freq_t freq,
	output logic            step
);

	logic [11:0] period;
	logic [11:0] count;

	// 2048 - freq, never zero
	assign period = wave_pkg::PERIOD_BASE - {1'b0, freq};

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			step  <= 1'b0;
		end else if (restart) begin
			count <= period;
			step  <= 1'b0;
		end else if (run) begin
			if (count <= 12'd1) begin
				count <= period; // picks up freq written mid-play
				step  <= 1'b1;
			end else begin
				count <= count - 12'd1;
				step  <= 1'b0;
			end
		end else begin
			step <= 1'b0; // hold count
		end
	end

endmodule

// ==== design/wave_length.sv ====
`timescale 1ns/100ps

module wave_length (
	input  logic           clk,
	input  logic           reset,
	input  logic           len_load,
	input  wave_pkg::len_t len_value,
	input  logic           len_tick,
	input  logic           enable,
	input  logic           restart,
	output logic           expired
);

	wave_pkg::len_t count;

	assign expired = (count == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (len_load) begin
			count <= len_value;
		end else if (restart && expired) begin
			count <= wave_pkg::LEN_MAX; // trigger on a spent counter
		end else if (len_tick && enable && !expired) begin
			count <= count - 9'd1;
		end
	end

endmodule

// ==== design/wave_ram.sv ====
`timescale 1ns/100ps

module wave_ram (
	input  logic                clk,
	input  logic                ram_we,
	input  logic [3:0]          ram_addr,
	input  wave_pkg::byte_t     ram_wdata,
	input  logic                active,
	input  wave_pkg::wave_pos_t pos,
	output wave_pkg::byte_t     ram_rdata,
	output wave_pkg::nibble_t   nibble
);

	wave_pkg::byte_t mem [16];
	logic [3:0]      rd_addr;

	// while playing the cpu sees the byte under the play head
	assign rd_addr = active ? pos[4:1] : ram_addr;

	always_ff @(posedge clk) begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
	end

	assign ram_rdata = mem[rd_addr];

	// high nibble first
	assign nibble = pos[0] ? ram_rdata[3:0] : ram_rdata[7:4];

endmodule

// ==== design/wave_volume.sv ====
`timescale 1ns/100ps

module wave_volume (
	input  logic                clk,
	input  logic                reset,
	input  logic                load_sample,
	input  logic                active,
	input  wave_pkg::vol_code_t vol,
	input  wave_pkg::nibble_t   nibble,
	input  logic                sample_ready,
	output logic                sample_valid,
	output wave_pkg::nibble_t   sample
);

	wave_pkg::nibble_t shifted;
	wave_pkg::nibble_t sample_q;

	always_comb begin
		case (vol)
			2'd1:    shifted = nibble;
			2'd2:    shifted = nibble >> 1;
			2'd3:    shifted = nibble >> 2;
			default: shifted = '0; // mute
		endcase
		if (!active)
			shifted = '0;
	end

	// a new step overwrites a waiting sample
	always_ff @(posedge clk) begin
		if (reset)
			sample_valid <= 1'b0;
		else if (load_sample)
			sample_valid <= 1'b1;
		else if (sample_ready)
			sample_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load_sample)
			sample_q <= shifted;
	end

	assign sample = active ? sample_q : '0; // silent when stopped

endmodule

// ==== design/wave_channel.sv ====
`timescale 1ns/100ps

module wave_channel (
	input  logic               clk,
	input  logic               reset,
	input  logic               req_valid,
	input  wave_pkg::cpu_req_t req,
	input  logic               len_tick,
	input  logic               sample_ready,
	output wave_pkg::byte_t    rdata,
	output logic               rsp_valid,
	output logic               sample_valid,
	output wave_pkg::nibble_t  sample,
	output logic               active
);

	wave_pkg::ch3_cfg_t  cfg;
	logic                trigger;
	logic                len_load;
	wave_pkg::len_t      len_value;
	logic                ram_we;
	logic [3:0]          ram_addr;
	wave_pkg::byte_t     ram_wdata;
	wave_pkg::byte_t     ram_rdata;
	logic                restart;
	wave_pkg::wave_pos_t pos;
	logic                load_sample;
	logic                step;
	logic                expired;
	wave_pkg::nibble_t   nibble;

	wave_regs u_regs (
		.clk, .reset, .req_valid, .req, .ram_rdata,
		.rdata, .rsp_valid, .cfg, .trigger, .len_load, .len_value,
		.ram_we, .ram_addr, .ram_wdata
	);

	wave_ctrl u_ctrl (
		.clk, .reset, .cfg, .trigger, .step, .expired,
		.active, .restart, .pos, .load_sample
	);

	wave_freq_timer u_timer (
		.clk, .reset, .restart,
		.run  (active),
		.freq (cfg.freq),
		.step
	);

	wave_length u_length (
		.clk, .reset, .len_load, .len_value, .len_tick,
		.enable (cfg.length_en),
		.restart, .expired
	);

	wave_ram u_ram (
		.clk, .ram_we, .ram_addr, .ram_wdata, .active, .pos,
		.ram_rdata, .nibble
	);

	wave_volume u_volume (
		.clk, .reset, .load_sample, .active,
		.vol (cfg.vol),
		.nibble, .sample_ready, .sample_valid, .sample
	);

endmodule

// ==== tests/wave_channel_asserts.sv ====
`timescale 1ns/100ps

module wave_channel_asserts (
	input logic               clk,
	input logic               reset,
	input logic               req_valid,
	input wave_pkg::cpu_req_t req,
	input logic               rsp_valid,
	input logic               sample_valid,
	input logic               sample_ready,
	input wave_pkg::nibble_t  sample,
	input logic               active
);

	// read response one cycle after accept
	assert property (@(posedge clk) disable iff (reset)
		(req_valid && !req.write) |=> rsp_valid)
		else $error("read request without response one cycle later");

	assert property (@(posedge clk) disable iff (reset)
		(sample_valid && !sample_ready) |=> sample_valid)
		else $error("sample_valid dropped before the sample was taken");

	assert property (@(posedge clk) disable iff (reset)
		!active |-> (sample == 4'd0))
		else $error("nonzero sample while channel inactive");

endmodule

bind wave_channel wave_channel_asserts u_asserts (
	.clk(clk), .reset(reset), .req_valid(req_valid), .req(req), .rsp_valid(rsp_valid),
	.sample_valid(sample_valid), .sample_ready(sample_ready), .sample(sample),
	.active(active)
);

// ==== tests/wave_channel_tb.sv ====
`timescale 1ns/100ps

module wave_channel_tb;

	localparam int MAX_CASES = 32;

	logic               clk = 1'b0;
	logic               reset;
	logic               req_valid;
	wave_pkg::cpu_req_t req;
	logic               len_tick;
	logic               sample_ready;
	wave_pkg::byte_t    rdata;
	logic               rsp_valid;
	logic               sample_valid;
	wave_pkg::nibble_t  sample;
	logic               active;

	int           c_kind [MAX_CASES];
	logic [7:0]   c_reg [MAX_CASES][5];
	logic [127:0] c_wave [MAX_CASES];
	int           c_ticks [MAX_CASES];
	int           c_exp [MAX_CASES];
	int           n_cases;
	int           test_errors;
	int           passed;
	int           failed;
	int           cycles;
	int           cycle_limit;
	int           seed;

	wave_channel u_wave_channel (
		.clk, .reset, .req_valid, .req, .len_tick, .sample_ready,
		.rdata, .rsp_valid, .sample_valid, .sample, .active
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	function automatic logic [7:0] byte_at(input logic [127:0] w, input int i);
		return w[127 - 8 * i -: 8];
	endfunction

	// high half first within each byte
	function automatic logic [3:0] nibble_at(input logic [127:0] w, input int idx);
		logic [7:0] b;
		b = byte_at(w, idx / 2);
		return (idx % 2 == 0) ? b[7:4] : b[3:0];
	endfunction

	function automatic logic [3:0] apply_volume(input logic [3:0] n, input logic [1:0] vol);
		case (vol)
			2'd1:    return n;
			2'd2:    return n >> 1;
			2'd3:    return n >> 2;
			default: return 4'd0;
		endcase
	endfunction

	function automatic int period_of(input int i);
		return 2048 - int'({c_reg[i][4][2:0], c_reg[i][3]});
	endfunction

	// play position after edge c counted from the trigger write
	function automatic int pos_after(input int c, input int p);
		if (c < p + 2)
			return 0;
		return ((c - (p + 2)) / p + 1) % 32;
	endfunction

	task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
		@(posedge clk);
		req_valid  <= 1'b1;
		req.write  <= 1'b1;
		req.addr   <= addr;
		req.wdata  <= data;
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [7:0] data);
		@(posedge clk);
		req_valid <= 1'b1;
		req.write <= 1'b0;
		req.addr  <= addr;
		@(posedge clk);
		req_valid <= 1'b0;
		@(negedge clk);
		check_value("rsp_valid", 16'(rsp_valid), 16'd1);
		data = rdata;
	endtask

	// nr34 last so a trigger sees the rest of the setup
	task automatic setup_case(input int i);
		@(posedge clk);
		sample_ready <= 1'b1;
		len_tick     <= 1'b0;
		for (int r = 0; r < 4; r++)
			write_reg(5'(r), c_reg[i][r]);
		for (int a = 0; a < 16; a++)
			write_reg(5'(16 + a), byte_at(c_wave[i], a));
		write_reg(5'd4, c_reg[i][4]);
	endtask

	task automatic regs_readback(input int i);
		logic [7:0] d;
		setup_case(i);
		read_reg(5'd0, d);
		check_value("nr30", 16'(d), 16'({c_reg[i][0][7], 7'h7f}));
		read_reg(5'd1, d);
		check_value("nr31", 16'(d), 16'hff);
		read_reg(5'd2, d);
		check_value("nr32", 16'(d), 16'({1'b1, c_reg[i][2][6:5], 5'h1f}));
		check_value("nr32 case value", 16'(d), 16'(c_exp[i]));
		read_reg(5'd3, d);
		check_value("nr33", 16'(d), 16'hff);
		read_reg(5'd4, d);
		check_value("nr34", 16'(d), 16'({1'b1, c_reg[i][4][6], 6'h3f}));
	endtask

	task automatic ram_readback(input int i);
		logic [7:0] d;
		logic [7:0] x;
		setup_case(i);
		x = 8'h00;
		for (int a = 0; a < 16; a++) begin
			read_reg(5'(16 + a), d);
			check_value("wave byte", 16'(d), 16'(byte_at(c_wave[i], a)));
			x = x ^ d;
		end
		check_value("wave checksum", 16'(x), 16'(c_exp[i]));
	endtask

	task automatic play_samples(input int i);
		int   p;
		int   c;
		int   got;
		int   last_rise;
		logic prev_valid;
		p = period_of(i);
		c = 0;
		got = 0;
		last_rise = -1;
		prev_valid = 1'b0;
		setup_case(i);
		while (got < c_exp[i] && c < 40 * p) begin
			@(posedge clk);
			c++;
			@(negedge clk);
			if (c == 1)
				check_value("active after trigger", 16'(active), 16'd1);
			if (sample_valid && !prev_valid) begin
				if (last_rise >= 0)
					check_value("step spacing", 16'(c - last_rise), 16'(p));
				last_rise = c;
			end
			prev_valid = sample_valid;
			if (sample_valid && sample_ready) begin
				check_value("sample", 16'(sample),
					16'(apply_volume(nibble_at(c_wave[i], (got + 1) % 32), c_reg[i][2][6:5])));
				got++;
			end
		end
		check_value("samples taken", 16'(got), 16'(c_exp[i]));
		write_reg(5'd0, 8'h00);
	endtask

	task automatic length_expiry(input int i);
		int p;
		p = period_of(i);
		setup_case(i);
		repeat (3) @(posedge clk);
		for (int t = 1; t <= c_ticks[i]; t++) begin
			@(posedge clk);
			len_tick <= 1'b1;
			@(posedge clk);
			len_tick <= 1'b0;
			@(negedge clk);
			check_value("active at count edge", 16'(active), 16'd1);
			@(posedge clk);
			@(negedge clk);
			check_value("active after tick", 16'(active), 16'(t < c_ticks[i]));
		end
		repeat (2 * p) begin
			@(negedge clk);
			check_value("sample after expiry", 16'(sample), 16'd0);
		end
		check_value("final active", 16'(active), 16'(c_exp[i]));
	endtask

	task automatic dac_control(input int i);
		int p;
		p = period_of(i);
		setup_case(i);
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (c_kind[i] == 4) begin
			check_value("active with dac off", 16'(active), 16'(c_exp[i]));
		end else begin
			check_value("active before dac clear", 16'(active), 16'd1);
			repeat (2 * p) @(posedge clk);
			write_reg(5'd0, 8'h00);
			@(negedge clk);
			check_value("active at dac write", 16'(active), 16'd1);
			@(posedge clk);
			@(negedge clk);
			check_value("active after dac clear", 16'(active), 16'(c_exp[i]));
		end
	endtask

	task automatic random_backpressure(input int i);
		int         p;
		int         c;
		int         got;
		int         rnd;
		logic       rd_pend;
		logic       chk_pend;
		logic [7:0] rd_exp;
		p = period_of(i);
		c = 0;
		got = 0;
		rd_pend = 1'b0;
		chk_pend = 1'b0;
		rd_exp = 8'h00;
		setup_case(i);
		while (got < c_exp[i] && c < 40 * p) begin
			@(posedge clk);
			c++;
			rnd = $random(seed);
			sample_ready <= rnd[0];
			if (rd_pend) begin
				chk_pend = 1'b1; // read accepted on this edge
				rd_exp = byte_at(c_wave[i], pos_after(c - 1, p) / 2);
				rd_pend = 1'b0;
				req_valid <= 1'b0;
			end else if (c % 7 == 3) begin
				req_valid <= 1'b1;
				req.write <= 1'b0;
				req.addr  <= 5'(16 + (c % 16));
				rd_pend = 1'b1;
			end
			@(negedge clk);
			if (chk_pend) begin
				check_value("rsp_valid in play", 16'(rsp_valid), 16'd1);
				check_value("read at play position", 16'(rdata), 16'(rd_exp));
				chk_pend = 1'b0;
			end
			if (sample_valid && sample_ready) begin
				check_value("sample under back-pressure", 16'(sample),
					16'(apply_volume(nibble_at(c_wave[i], pos_after(c - 1, p)),
					c_reg[i][2][6:5])));
				got++;
			end
		end
		check_value("samples taken", 16'(got), 16'(c_exp[i]));
		write_reg(5'd0, 8'h00);
	endtask

	task automatic load_cases();
		int         fd;
		int         k;
		int         t;
		int         e;
		logic [7:0] r [5];
		logic [127:0] w;
		string      line;
		n_cases = 0;
		fd = $fopen("tests/wave_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 0 && line.getc(0) != 8'h23 && n_cases < MAX_CASES) begin
					if ($sscanf(line, "%h %h %h %h %h %h %h %d %h",
						k, r[0], r[1], r[2], r[3], r[4], w, t, e) == 9) begin
						c_kind[n_cases] = k;
						for (int j = 0; j < 5; j++)
							c_reg[n_cases][j] = r[j];
						c_wave[n_cases] = w;
						c_ticks[n_cases] = t;
						c_exp[n_cases] = e;
						n_cases++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		int sum;
		seed = 49;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		len_tick = 1'b0;
		sample_ready = 1'b1;
		passed = 0;
		failed = 0;
		cycles = 0;
		cycle_limit = 0;
		load_cases();
		sum = 0;
		for (int i = 0; i < n_cases; i++) begin
			sum += 2000;
			if (c_kind[i] == 2 || c_kind[i] == 5 || c_kind[i] == 6)
				sum += 32 * period_of(i);
		end
		cycle_limit = 2 * sum;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		if (n_cases == 0) begin
			$display("no cases were read from the case file");
			failed++;
		end
		for (int i = 0; i < n_cases; i++) begin
			test_errors = 0;
			case (c_kind[i])
				0:       regs_readback(i);
				1:       ram_readback(i);
				2:       play_samples(i);
				3:       length_expiry(i);
				4, 5:    dac_control(i);
				6:       random_backpressure(i);
				default: begin
					$display("case %0d has an unknown kind %0d", i, c_kind[i]);
					test_errors++;
				end
			endcase
			if (test_errors == 0)
				passed++;
			else
				failed++;
			$display("test %0d kind %0d: %0d errors", i, c_kind[i], test_errors);
		end
		$display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
		if (failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== wave_channel.f ====
design/wave_pkg.sv
design/wave_regs.sv
design/wave_ctrl.sv
design/wave_freq_timer.sv
design/wave_length.sv
design/wave_ram.sv
design/wave_volume.sv
design/wave_channel.sv
tests/wave_channel_asserts.sv
tests/wave_channel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the wave channel testbench with Verilator
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert --top-module wave_channel_tb \
	-f wave_channel.f -o sim_wave &&
./obj_dir/sim_wave | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation PASSED" && exit 0 ||
{ echo "simulation FAILED"; exit 1; }

// ==== tests/wave_cases.txt ====
# kind nr30 nr31 nr32 nr33 nr34 wave_bytes(16, byte 0 first) ticks(dec) expect
# kind 0 regs, 1 ram, 2 play, 3 length, 4 trigger dac off, 5 dac clear, 6 back-pressure
0 80 00 40 aa 40 00000000000000000000000000000000 0 df
0 00 3c 20 12 00 00000000000000000000000000000000 0 bf

1 00 00 00 00 00 0123456789abcdeffedcba9876543210 0 00
1 00 00 00 00 00 c3000000000000000000000000000007 0 c4

2 80 00 00 f0 87 0123456789abcdeffedcba9876543210 0 20
2 80 00 20 f0 87 0123456789abcdeffedcba9876543210 0 20
2 80 00 40 e0 87 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 20
2 80 00 60 f0 87 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 20

3 80 fb 20 f0 c7 0123456789abcdeffedcba9876543210 5 00
3 80 ff 20 f0 c7 fedcba98765432100123456789abcdef 1 00

4 00 00 20 f0 87 0123456789abcdeffedcba9876543210 0 00
5 80 00 20 f0 87 0123456789abcdeffedcba9876543210 0 00

6 80 00 20 f0 87 0123456789abcdeffedcba9876543210 0 18
6 80 00 60 e0 87 f0e1d2c3b4a5968778695a4b3c2d1e0f 0 18
